/* rtl/avcPkg.sv */
`default_nettype none

package avcPkg;

	parameter int PipeDepth = 4;                   // Counter to video output, in DOTCLK cycles
	parameter int TileBits = 8;                    // Width of a tile number
	parameter int TileSize = 8;                    // Tile edge in pixels
	parameter int MapCols = 64;
	parameter int MapRows = 32;

	parameter logic [15:0] TileBase = 16'h8000;    // 16 KiB tile pixel window
	parameter logic [15:0] MapBase = 16'hC000;     // 2048 map entries
	parameter logic [15:0] ScrollXAddr = 16'hC800;
	parameter logic [15:0] ScrollYAddr = 16'hC801;
	parameter logic [15:0] PaletteBase = 16'hD000; // 256 palette entries

	typedef struct packed {
		logic valid;
		logic [15:0] addr;
		logic [8:0] data;
	} busWrite_t;

	typedef struct packed {
		logic spare;        // Not stored
		logic [7:0] index;
	} pixelView_t;

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} paletteView_t;

	// Tile and map writes carry a colour index, palette writes carry RGB
	typedef union packed {
		pixelView_t pixel;
		paletteView_t palette;
	} busData_u;

	typedef struct packed {
		logic tileWe;
		logic mapWe;
		logic scrollXWe;
		logic scrollYWe;
		logic paletteWe;
		logic [13:0] offset; // Relative to the region base
		busData_u data;
	} regionWrite_t;

	typedef struct packed {
		logic [8:0] x;
		logic [7:0] y;       // Line number halved
	} rasterPos_t;

	typedef struct packed {
		logic hsync;         // Active low
		logic vsync;         // Active high
		logic vblank;
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} videoOut_t;

endpackage

`default_nettype wire

/* rtl/busDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module busDecode (
	input logic DOTCLK,
	input logic rst,
	input avcPkg::busWrite_t bus,
	output avcPkg::regionWrite_t regWr
);

	localparam logic [15:0] MapEnd = avcPkg::MapBase
		+ 16'(avcPkg::MapCols * avcPkg::MapRows);
	localparam logic [15:0] PaletteEnd = avcPkg::PaletteBase + 16'h0100;

	logic isTile;
	logic isMap;
	logic isScrollX;
	logic isScrollY;
	logic isPalette;
	logic [15:0] base;
	logic [15:0] relAddr;

	always_comb begin
		isTile = bus.valid && (bus.addr >= avcPkg::TileBase) && (bus.addr < avcPkg::MapBase);
		isMap = bus.valid && (bus.addr >= avcPkg::MapBase) && (bus.addr < MapEnd);
		isScrollX = bus.valid && (bus.addr == avcPkg::ScrollXAddr);
		isScrollY = bus.valid && (bus.addr == avcPkg::ScrollYAddr);
		isPalette = bus.valid && (bus.addr >= avcPkg::PaletteBase) && (bus.addr < PaletteEnd);

		// Sprite and audio space falls through with no strobe
		if (isPalette) begin
			base = avcPkg::PaletteBase;
		end else if (isMap) begin
			base = avcPkg::MapBase;
		end else begin
			base = avcPkg::TileBase;
		end
		relAddr = bus.addr - base;
	end

	always_ff @(posedge DOTCLK) begin
		if (rst) begin
			regWr.tileWe <= 1'b0;
			regWr.mapWe <= 1'b0;
			regWr.scrollXWe <= 1'b0;
			regWr.scrollYWe <= 1'b0;
			regWr.paletteWe <= 1'b0;
		end else begin
			regWr.tileWe <= isTile;
			regWr.mapWe <= isMap;
			regWr.scrollXWe <= isScrollX;
			regWr.scrollYWe <= isScrollY;
			regWr.paletteWe <= isPalette;
		end
		regWr.offset <= relAddr[13:0]; // Widest region is the 14-bit tile window
		regWr.data <= bus.data;
	end

endmodule

`default_nettype wire

/* rtl/videoTiming.sv */
`timescale 1ns/1ps
`default_nettype none

module videoTiming #(
	parameter int HActive = 320,
	parameter int HSyncStart = 327,
	parameter int HSyncEnd = 374,
	parameter int HTotal = 400,
	parameter int VActive = 400,
	parameter int VSyncStart = 411,
	parameter int VSyncEnd = 412,
	parameter int VTotal = 449
) (
	input logic DOTCLK,
	input logic rst,
	output avcPkg::rasterPos_t pos,
	output logic blank,
	output logic hsync,
	output logic vsync,
	output logic vblank
);

	localparam int Depth = avcPkg::PipeDepth;

	logic [8:0] xCount;
	logic [8:0] yCount;
	logic hsyncNow;
	logic vsyncNow;
	logic vblankNow;
	logic blankNow;
	logic [Depth-1:0] hsyncPipe;
	logic [Depth-1:0] vsyncPipe;
	logic [Depth-1:0] vblankPipe;
	logic [Depth-2:0] blankPipe; // One short, paletteOut registers it

	always_ff @(posedge DOTCLK) begin
		if (rst) begin
			xCount <= '0;
			yCount <= '0;
		end else if (xCount == 9'(HTotal - 1)) begin
			xCount <= '0;
			yCount <= (yCount == 9'(VTotal - 1)) ? '0 : yCount + 9'd1;
		end else begin
			xCount <= xCount + 9'd1;
		end
	end

	assign hsyncNow = !((xCount >= 9'(HSyncStart)) && (xCount <= 9'(HSyncEnd)));
	assign vsyncNow = (yCount >= 9'(VSyncStart)) && (yCount <= 9'(VSyncEnd));
	assign vblankNow = yCount >= 9'(VActive);
	assign blankNow = vblankNow || (xCount >= 9'(HActive));

	always_ff @(posedge DOTCLK) begin
		if (rst) begin
			hsyncPipe <= '1;  // Inactive levels until real data reaches the end
			vsyncPipe <= '0;
			vblankPipe <= '1;
			blankPipe <= '1;
		end else begin
			hsyncPipe <= {hsyncPipe[Depth-2:0], hsyncNow};
			vsyncPipe <= {vsyncPipe[Depth-2:0], vsyncNow};
			vblankPipe <= {vblankPipe[Depth-2:0], vblankNow};
			blankPipe <= {blankPipe[Depth-3:0], blankNow};
		end
	end

	// Map lookup starts one cycle behind the counters
	// so the three pixel stages finish at PipeDepth
	always_ff @(posedge DOTCLK) begin
		pos <= '{x: xCount, y: yCount[8:1]};
	end

	assign hsync = hsyncPipe[Depth-1];
	assign vsync = vsyncPipe[Depth-1];
	assign vblank = vblankPipe[Depth-1];
	assign blank = blankPipe[Depth-2];

endmodule

`default_nettype wire

/* rtl/tileMap.sv */
`timescale 1ns/1ps
`default_nettype none

module tileMap (
	input logic DOTCLK,
	input avcPkg::regionWrite_t regWr,
	input avcPkg::rasterPos_t pos,
	output logic [avcPkg::TileBits-1:0] tile,
	output logic [2:0] tileCol,
	output logic [2:0] tileRow
);

	localparam int MapEntries = avcPkg::MapCols * avcPkg::MapRows;
	localparam int MapAddrBits = $clog2(MapEntries);
	localparam int TileShift = $clog2(avcPkg::TileSize);

	logic [avcPkg::TileBits-1:0] mapMem [MapEntries];
	logic [8:0] scrollX;
	logic [7:0] scrollY;
	logic [8:0] xAdj;
	logic [7:0] yAdj;
	logic [MapAddrBits-1:0] mapIndex;

	always_ff @(posedge DOTCLK) begin
		if (regWr.mapWe) begin
			mapMem[regWr.offset[MapAddrBits-1:0]] <= regWr.data.pixel.index;
		end
		if (regWr.scrollXWe) begin
			scrollX <= regWr.data; // Full 9 bits
		end
		if (regWr.scrollYWe) begin
			scrollY <= regWr.data.pixel.index;
		end
	end

	// Both sums wrap at their natural width
	assign xAdj = pos.x + scrollX;
	assign yAdj = pos.y + scrollY;
	assign mapIndex = MapAddrBits'((yAdj >> TileShift) * avcPkg::MapCols
		+ (xAdj >> TileShift));

	always_ff @(posedge DOTCLK) begin
		tile <= mapMem[mapIndex];
		tileCol <= xAdj[2:0];
		tileRow <= yAdj[2:0];
	end

endmodule

`default_nettype wire

/* rtl/tilePixels.sv */
`timescale 1ns/1ps
`default_nettype none

module tilePixels (
	input logic DOTCLK,
	input avcPkg::regionWrite_t regWr,
	input logic [avcPkg::TileBits-1:0] tile,
	input logic [2:0] tileCol,
	input logic [2:0] tileRow,
	output logic [7:0] colorIndex
);

	localparam int AddrBits = avcPkg::TileBits + 2 * $clog2(avcPkg::TileSize);

	logic [7:0] tileMem [2**AddrBits];
	logic [AddrBits-1:0] pixelAddr;

	assign pixelAddr = {tile, tileRow, tileCol}; // 64 bytes per tile, row major

	always_ff @(posedge DOTCLK) begin
		if (regWr.tileWe) begin
			tileMem[regWr.offset[AddrBits-1:0]] <= regWr.data.pixel.index;
		end
		colorIndex <= tileMem[pixelAddr];
	end

endmodule

`default_nettype wire

/* rtl/paletteOut.sv */
`timescale 1ns/1ps
`default_nettype none

module paletteOut (
	input logic DOTCLK,
	input logic rst,
	input avcPkg::regionWrite_t regWr,
	input logic [7:0] colorIndex,
	input logic blank,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [2:0] blue
);

	avcPkg::paletteView_t palMem [256];
	avcPkg::paletteView_t entry;

	always_ff @(posedge DOTCLK) begin
		if (regWr.paletteWe) begin
			palMem[regWr.offset[7:0]] <= regWr.data.palette;
		end
	end

	assign entry = palMem[colorIndex];

	always_ff @(posedge DOTCLK) begin
		if (rst || blank) begin
			red <= '0;            // Black outside the active area
			green <= '0;
			blue <= '0;
		end else begin
			red <= entry.red;
			green <= entry.green;
			blue <= entry.blue;
		end
	end

endmodule

`default_nettype wire

/* rtl/avcTop.sv */
`timescale 1ns/1ps
`default_nettype none

module avcTop #(
	parameter int HActive = 320,
	parameter int HSyncStart = 327,
	parameter int HSyncEnd = 374,
	parameter int HTotal = 400,
	parameter int VActive = 400,
	parameter int VSyncStart = 411,
	parameter int VSyncEnd = 412,
	parameter int VTotal = 449
) (
	input logic DOTCLK,
	input logic rst,
	input avcPkg::busWrite_t bus,
	output avcPkg::videoOut_t video
);

	avcPkg::regionWrite_t regWr;
	avcPkg::rasterPos_t pos;
	logic blank;
	logic hsync;
	logic vsync;
	logic vblank;
	logic [avcPkg::TileBits-1:0] tile;
	logic [2:0] tileCol;
	logic [2:0] tileRow;
	logic [7:0] colorIndex;
	logic [2:0] red;
	logic [2:0] green;
	logic [2:0] blue;

	busDecode i_busDecode (
		.DOTCLK(DOTCLK),
		.rst(rst),
		.bus(bus),
		.regWr(regWr)
	);

	videoTiming #(
		.HActive(HActive),
		.HSyncStart(HSyncStart),
		.HSyncEnd(HSyncEnd),
		.HTotal(HTotal),
		.VActive(VActive),
		.VSyncStart(VSyncStart),
		.VSyncEnd(VSyncEnd),
		.VTotal(VTotal)
	) i_videoTiming (
		.DOTCLK(DOTCLK),
		.rst(rst),
		.pos(pos),
		.blank(blank),
		.hsync(hsync),
		.vsync(vsync),
		.vblank(vblank)
	);

	tileMap i_tileMap (
		.DOTCLK(DOTCLK),
		.regWr(regWr),
		.pos(pos),
		.tile(tile),
		.tileCol(tileCol),
		.tileRow(tileRow)
	);

	tilePixels i_tilePixels (
		.DOTCLK(DOTCLK),
		.regWr(regWr),
		.tile(tile),
		.tileCol(tileCol),
		.tileRow(tileRow),
		.colorIndex(colorIndex)
	);

	paletteOut i_paletteOut (
		.DOTCLK(DOTCLK),
		.rst(rst),
		.regWr(regWr),
		.colorIndex(colorIndex),
		.blank(blank),
		.red(red),
		.green(green),
		.blue(blue)
	);

	// Sync fields and RGB leave their blocks already aligned
	assign video = '{hsync: hsync, vsync: vsync, vblank: vblank,
		red: red, green: green, blue: blue};

endmodule

`default_nettype wire

/* verif/avcChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module avcChecker #(
	parameter int HActive = 320,
	parameter int HSyncStart = 327,
	parameter int HSyncEnd = 374,
	parameter int HTotal = 400,
	parameter int VActive = 400,
	parameter int VSyncStart = 411,
	parameter int VSyncEnd = 412,
	parameter int VTotal = 449
) (
	input logic DOTCLK,
	input logic rst,
	input avcPkg::busWrite_t bus,
	input avcPkg::videoOut_t video,
	output int resetErrors,
	output int syncErrors,
	output int pixelErrors,
	output int pixelsChecked
);

	localparam int Depth = avcPkg::PipeDepth;
	localparam int PrintLimit = 20;

	typedef struct packed {
		logic [8:0] x;
		logic [8:0] line;
		logic check;     // Frame was quiet when this position was counted
	} rasterSlot_t;

	logic [7:0] mapShadow [2048];
	logic [7:0] tileShadow [16384];
	logic [8:0] palShadow [256];   // Red, green, blue from high to low
	logic [8:0] scrollX;
	logic [7:0] scrollY;
	rasterSlot_t inFlight [$];
	rasterSlot_t slot;
	int xNow;
	int lineNow;
	int sinceWrite;
	logic frameOk;

	initial begin
		resetErrors = 0;
		syncErrors = 0;
		pixelErrors = 0;
		pixelsChecked = 0;
	end

	task automatic printError(input string msg);
		if (resetErrors + syncErrors + pixelErrors <= PrintLimit) begin
			$display("Error at %0d ns: %s", $time, msg);
		end
	endtask

	function automatic logic [8:0] expectedColor(input int x, input int line);
		int sx;
		int sy;
		int idx;
		logic [7:0] tileNum;
		logic [7:0] pixel;
		sx = (x + scrollX) % 512;
		sy = (line / 2 + scrollY) % 256;
		idx = (sy / avcPkg::TileSize) * avcPkg::MapCols + sx / avcPkg::TileSize;
		tileNum = mapShadow[idx];
		pixel = tileShadow[tileNum * 64 + (sy % 8) * 8 + sx % 8];
		return palShadow[pixel];
	endfunction

	task automatic snoopWrite(input avcPkg::busWrite_t w);
		if (w.addr >= avcPkg::TileBase && w.addr <= 16'hBFFF) begin
			tileShadow[w.addr - avcPkg::TileBase] = w.data[7:0];
		end else if (w.addr >= avcPkg::MapBase && w.addr <= 16'hC7FF) begin
			mapShadow[w.addr - avcPkg::MapBase] = w.data[7:0];
		end else if (w.addr == avcPkg::ScrollXAddr) begin
			scrollX = w.data;
		end else if (w.addr == avcPkg::ScrollYAddr) begin
			scrollY = w.data[7:0];
		end else if (w.addr >= avcPkg::PaletteBase && w.addr <= 16'hD0FF) begin
			palShadow[w.addr - avcPkg::PaletteBase] = w.data;
		end
	endtask

	task automatic checkInactive(input string when);
		if (video.hsync !== 1'b1 || video.vsync !== 1'b0 || video.vblank !== 1'b1
			|| {video.red, video.green, video.blue} !== 9'd0) begin
			resetErrors++;
			printError($sformatf("outputs not inactive %s: hsync %b vsync %b vblank %b rgb %h",
				when, video.hsync, video.vsync, video.vblank,
				{video.red, video.green, video.blue}));
		end
	endtask

	task automatic checkSlot(input rasterSlot_t s);
		logic expHsync;
		logic expVsync;
		logic expVblank;
		logic blank;
		logic [8:0] rgb;
		logic [8:0] expRgb;
		expHsync = !((s.x >= HSyncStart) && (s.x <= HSyncEnd));
		expVsync = (s.line >= VSyncStart) && (s.line <= VSyncEnd);
		expVblank = s.line >= VActive;
		blank = expVblank || (s.x >= HActive);
		rgb = {video.red, video.green, video.blue};
		if (video.hsync !== expHsync || video.vsync !== expVsync || video.vblank !== expVblank) begin
			syncErrors++;
			printError($sformatf("hsync/vsync/vblank %b%b%b, expected %b%b%b at x=%0d line=%0d",
				video.hsync, video.vsync, video.vblank, expHsync, expVsync, expVblank,
				s.x, s.line));
		end
		if (blank) begin
			if (rgb !== 9'd0) begin
				syncErrors++;
				printError($sformatf("rgb %h in blanking at x=%0d line=%0d", rgb, s.x, s.line));
			end
		end else if (s.check && sinceWrite >= Depth) begin // No write while it was in flight
			expRgb = expectedColor(s.x, s.line);
			pixelsChecked++;
			if (rgb !== expRgb) begin
				pixelErrors++;
				printError($sformatf("rgb %h, expected %h at x=%0d line=%0d",
					rgb, expRgb, s.x, s.line));
			end
		end
	endtask

	always @(negedge DOTCLK) begin
		if (rst) begin
			checkInactive("during reset");
			inFlight.delete();
			xNow = 0;
			lineNow = 0;
			sinceWrite = 0;  // First frame after reset holds no loaded data
			frameOk = 1'b0;
		end else begin
			if (inFlight.size() == Depth) begin
				checkSlot(inFlight.pop_front());
			end else begin
				checkInactive("after reset");
			end
			if (sinceWrite < 1000000) begin
				sinceWrite++;
			end
			if (xNow == 0 && lineNow == 0) begin
				frameOk = sinceWrite >= Depth + 2;
			end
			slot.x = 9'(xNow);
			slot.line = 9'(lineNow);
			slot.check = frameOk;
			if (bus.valid) begin
				slot.check = 1'b0;
				frameOk = 1'b0; // Rest of this frame is not compared
				sinceWrite = 0;
				snoopWrite(bus);
			end
			inFlight.push_back(slot);
			if (xNow == HTotal - 1) begin
				xNow = 0;
				lineNow = (lineNow == VTotal - 1) ? 0 : lineNow + 1;
			end else begin
				xNow++;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/avcTb.sv */
`timescale 1ns/1ps
`default_nettype none

module avcTb;

	localparam int HActive = 32;
	localparam int HSyncStart = 36;
	localparam int HSyncEnd = 40;
	localparam int HTotal = 48;
	localparam int VActive = 24;
	localparam int VSyncStart = 26;
	localparam int VSyncEnd = 27;
	localparam int VTotal = 30;
	localparam int FrameCycles = HTotal * VTotal;

	localparam logic [1:0] PhLoad = 2'd0;
	localparam logic [1:0] PhScroll = 2'd1;
	localparam logic [1:0] PhRepalette = 2'd2;
	localparam logic [1:0] PhIgnored = 2'd3;

	typedef struct packed {
		logic [1:0] phase;
		logic [15:0] addr;
		logic [8:0] data;
	} stimRow_t;

	logic DOTCLK = 1'b0;
	logic rst;
	avcPkg::busWrite_t bus;
	avcPkg::videoOut_t video;
	int seed;
	stimRow_t stim [$];
	int row;
	logic timedOut;
	int resetErrors;
	int syncErrors;
	int pixelErrors;
	int pixelsChecked;

	avcTop #(
		.HActive(HActive), .HSyncStart(HSyncStart), .HSyncEnd(HSyncEnd), .HTotal(HTotal),
		.VActive(VActive), .VSyncStart(VSyncStart), .VSyncEnd(VSyncEnd), .VTotal(VTotal)
	) i_dut (
		.DOTCLK(DOTCLK),
		.rst(rst),
		.bus(bus),
		.video(video)
	);

	avcChecker #(
		.HActive(HActive), .HSyncStart(HSyncStart), .HSyncEnd(HSyncEnd), .HTotal(HTotal),
		.VActive(VActive), .VSyncStart(VSyncStart), .VSyncEnd(VSyncEnd), .VTotal(VTotal)
	) i_checker (
		.DOTCLK(DOTCLK),
		.rst(rst),
		.bus(bus),
		.video(video),
		.resetErrors(resetErrors),
		.syncErrors(syncErrors),
		.pixelErrors(pixelErrors),
		.pixelsChecked(pixelsChecked)
	);

	always #10 DOTCLK = ~DOTCLK;

	task automatic addRow(input logic [1:0] phase, input logic [15:0] addr, input logic [8:0] data);
		stimRow_t r;
		r.phase = phase;
		r.addr = addr;
		r.data = data;
		stim.push_back(r);
	endtask

	task automatic buildTable();
		int i;
		int k;
		logic [7:0] tileNum;
		for (k = 0; k < 16; k++) begin // 16 tiles spread over the whole tile number range
			for (i = 0; i < 64; i++) begin
				addRow(PhLoad, avcPkg::TileBase + 16'(k * 17 * 64 + i), 9'($random(seed)));
			end
		end
		for (i = 0; i < 2048; i++) begin
			tileNum = 8'(($random(seed) & 15) * 17);
			addRow(PhLoad, avcPkg::MapBase + 16'(i), {1'($random(seed)), tileNum});
		end
		for (i = 0; i < 256; i++) begin
			addRow(PhLoad, avcPkg::PaletteBase + 16'(i), 9'($random(seed)));
		end
		addRow(PhLoad, avcPkg::ScrollXAddr, 9'd0);
		addRow(PhLoad, avcPkg::ScrollYAddr, 9'd0);
		addRow(PhScroll, avcPkg::ScrollXAddr, 9'd13);
		addRow(PhScroll, avcPkg::ScrollYAddr, 9'd5);
		for (i = 0; i < 256; i += 2) begin // Every other palette entry gets a new colour
			addRow(PhRepalette, avcPkg::PaletteBase + 16'(i), 9'($random(seed)));
		end
		addRow(PhScroll, avcPkg::ScrollXAddr, 9'h1F5); // Both sums wrap
		addRow(PhScroll, avcPkg::ScrollYAddr, 9'h1FA); // Bit 8 is not part of scroll Y
		addRow(PhIgnored, 16'h0000, 9'($random(seed))); // Old sprite space
		addRow(PhIgnored, 16'h3A5C, 9'($random(seed)));
		addRow(PhIgnored, 16'h7FFF, 9'($random(seed)));
		addRow(PhIgnored, 16'hE000, 9'($random(seed)));
		addRow(PhIgnored, 16'hE7A1, 9'($random(seed)));
		addRow(PhIgnored, 16'hEFFF, 9'($random(seed)));
		addRow(PhIgnored, 16'hF000, 9'($random(seed))); // Audio
		addRow(PhIgnored, 16'hF0FF, 9'($random(seed)));
	endtask

	task automatic driveWrite(input stimRow_t r);
		@(posedge DOTCLK);
		#1;
		bus.valid = 1'b1;
		bus.addr = r.addr;
		bus.data = r.data;
	endtask

	task automatic releaseBus();
		@(posedge DOTCLK);
		#1;
		bus = '0;
	endtask

	// Counts rising edges of vsync at the video output
	task automatic waitFrames(input int frames, output logic late);
		int cycles;
		int rises;
		logic lastVsync;
		cycles = 0;
		rises = 0;
		late = 1'b0;
		lastVsync = video.vsync;
		while (rises < frames && !late) begin
			@(negedge DOTCLK);
			if (video.vsync === 1'b1 && lastVsync !== 1'b1) begin
				rises++;
			end
			lastVsync = video.vsync;
			cycles++;
			if (rises < frames && cycles >= (frames + 1) * FrameCycles) begin
				late = 1'b1;
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		bus = '0;
		seed = 32'h8d53c362;
		timedOut = 1'b0;
		buildTable();
		repeat (8) @(posedge DOTCLK);
		#1;
		rst = 1'b0;

		row = 0;
		while (row < stim.size() && !timedOut) begin
			driveWrite(stim[row]);
			row++;
			if (row == stim.size() || stim[row].phase != stim[row - 1].phase) begin
				releaseBus(); // End of a phase
				waitFrames(2, timedOut);
			end
		end

		$display("Done: %0d reset errors, %0d sync errors, %0d pixel errors, %0d pixels compared",
			resetErrors, syncErrors, pixelErrors, pixelsChecked);
		if (timedOut) begin
			$display("Timeout: vsync did not rise twice after the write at row %0d", row);
			$display("STATUS: FAIL");
		end else if (resetErrors + syncErrors + pixelErrors != 0 || pixelsChecked == 0) begin
			if (pixelsChecked == 0) begin
				$display("No visible pixel was ever compared");
			end
			$display("STATUS: FAIL");
		end else begin
			$display("STATUS: PASS");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
rtl/avcPkg.sv
rtl/busDecode.sv
rtl/videoTiming.sv
rtl/tileMap.sv
rtl/tilePixels.sv
rtl/paletteOut.sv
rtl/avcTop.sv
verif/avcChecker.sv
verif/avcTb.sv

/* Bender.yml */
package:
  name: avc_tile_video

sources:
  # Design, package first
  - files:
      - rtl/avcPkg.sv
      - rtl/busDecode.sv
      - rtl/videoTiming.sv
      - rtl/tileMap.sv
      - rtl/tilePixels.sv
      - rtl/paletteOut.sv
      - rtl/avcTop.sv

  # Testbench, top module avcTb
  - target: simulation
    files:
      - verif/avcChecker.sv
      - verif/avcTb.sv
